//--- src/sram_test_params.svh
`ifndef SRAM_TEST_PARAMS_SVH
`define SRAM_TEST_PARAMS_SVH

// Select field plus command payload
`define PACKET_W 84

// Command payload shared by the narrow and wide views
`define PAYLOAD_W 82

// 256 words per macro
`define ADDR_W 8

// Macros on the test chip
`define NUM_MACROS 3

`endif

//--- src/sram_test_pkg.sv
`default_nettype none

`include "sram_test_params.svh"

package sram_test_pkg;

  // Which macro the packet targets
  typedef enum logic [1:0] {
    SEL_NARROW_DP = 2'd0,  // 32-bit, RW plus RO port
    SEL_NARROW_SP = 2'd1,  // 32-bit, RW only
    SEL_WIDE      = 2'd2,  // 64-bit, RW only
    SEL_NONE      = 2'd3
  } macro_sel_e;

  // Bits the narrow view uses before padding
  localparam int NARROW_USED_W = 2 + 4 + `ADDR_W + 32 + 1 + `ADDR_W;

  // Narrow macro command, port 0 read/write and port 1 read-only
  typedef struct packed {
    logic                                    csb0;   // Active low
    logic                                    web0;   // Active low
    logic [3:0]                              wmask;
    logic [`ADDR_W-1:0]                      addr0;
    logic [31:0]                             din0;
    logic                                    csb1;   // Active low, RO port
    logic [`ADDR_W-1:0]                      addr1;
    logic [`PAYLOAD_W-NARROW_USED_W-1:0]     pad;
  } narrow_cmd_t;

  // Wide macro command, single read/write port
  typedef struct packed {
    logic               csb0;
    logic               web0;
    logic [7:0]         wmask;  // One bit per byte
    logic [`ADDR_W-1:0] addr0;
    logic [63:0]        din0;
  } wide_cmd_t;

  // Same payload word, decoded by the select
  typedef union packed {
    narrow_cmd_t narrow;
    wide_cmd_t   wide;
  } cmd_payload_u;

  // Full command packet from the host
  typedef struct packed {
    macro_sel_e   sel;
    cmd_payload_u payload;
  } test_packet_t;

  // Routed bundle to one macro, all zero when idle
  typedef struct packed {
    logic         strobe;
    cmd_payload_u payload;
  } macro_pins_t;

endpackage

`default_nettype wire

//--- src/gpio_packet_deserializer.sv
`default_nettype none

`include "sram_test_params.svh"

module gpio_packet_deserializer (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        gpio_bit,
  input  logic                        gpio_valid,
  output sram_test_pkg::test_packet_t packet
);

  import sram_test_pkg::*;

  localparam int CNT_W = $clog2(`PACKET_W);

  logic [`PACKET_W-1:0] shift_q;
  logic [`PACKET_W-1:0] shift_next;
  logic [CNT_W-1:0]     bit_cnt;  // Bits received in current packet

  assign shift_next = {shift_q[`PACKET_W-2:0], gpio_bit};  // MSB arrives first

  always_ff @(posedge clk) begin
    if (gpio_valid) begin
      shift_q <= shift_next;
    end
  end

  // Output only moves once a whole packet has been shifted in
  always_ff @(posedge clk) begin
    if (reset) begin
      bit_cnt        <= '0;
      packet.sel     <= SEL_NONE;
      packet.payload <= '0;
    end else if (gpio_valid) begin
      if (bit_cnt == CNT_W'(`PACKET_W - 1)) begin
        bit_cnt <= '0;
        packet  <= test_packet_t'(shift_next);  // Last bit lands here
      end else begin
        bit_cnt <= bit_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- src/sram_port_router.sv
`default_nettype none

`include "sram_test_params.svh"

module sram_port_router (
  input  logic                        clk,
  input  logic                        reset,
  input  sram_test_pkg::test_packet_t packet_in,
  output sram_test_pkg::macro_pins_t  macro_pins [`NUM_MACROS],
  input  logic [31:0]                 rw_dout0,
  input  logic [31:0]                 ro_dout0,
  input  logic [31:0]                 rw_dout1,
  input  logic [63:0]                 rw_dout2,
  output logic [63:0]                 sram_data
);

  import sram_test_pkg::*;

  test_packet_t packet_q;   // Active packet
  logic         strobe;     // Half-rate pacing for the macros
  logic         act_csb0;
  logic         act_web0;
  logic [63:0]  read_mux;
  logic [63:0]  read_data;  // First stage of the read pipeline

  // Packet register and strobe divider
  always_ff @(posedge clk) begin
    if (reset) begin
      packet_q.sel     <= SEL_NONE;
      packet_q.payload <= '0;
      strobe           <= 1'b0;
    end else begin
      packet_q <= packet_in;
      strobe   <= ~strobe;
    end
  end

  // Pick the payload view that matches the target macro
  always_comb begin
    case (packet_q.sel)
      SEL_NARROW_DP, SEL_NARROW_SP: begin
        act_csb0 = packet_q.payload.narrow.csb0;
        act_web0 = packet_q.payload.narrow.web0;
      end
      SEL_WIDE: begin
        act_csb0 = packet_q.payload.wide.csb0;
        act_web0 = packet_q.payload.wide.web0;
      end
      default: begin
        act_csb0 = 1'b1;  // Nothing selected reads as idle
        act_web0 = 1'b1;
      end
    endcase
  end

  // Only the selected macro sees strobe and payload
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `NUM_MACROS; i++) begin
        macro_pins[i] <= '0;
      end
    end else begin
      for (int i = 0; i < `NUM_MACROS; i++) begin
        if (int'(packet_q.sel) == i) begin
          macro_pins[i].strobe  <= strobe;
          macro_pins[i].payload <= packet_q.payload;
        end else begin
          macro_pins[i] <= '0;
        end
      end
    end
  end

  // Narrow outputs are zero-extended to 64 bits
  always_comb begin
    case (packet_q.sel)
      SEL_NARROW_DP: read_mux = {32'd0, act_csb0 ? ro_dout0 : rw_dout0};
      SEL_NARROW_SP: read_mux = {32'd0, rw_dout1};
      SEL_WIDE:      read_mux = rw_dout2;
      default:       read_mux = '0;
    endcase
  end

  // Capture while the active packet is a read, then one more stage out
  always_ff @(posedge clk) begin
    if (reset) begin
      read_data <= '0;
      sram_data <= '0;
    end else begin
      if (act_web0) begin
        read_data <= read_mux;
      end
      sram_data <= read_data;
    end
  end

endmodule

`default_nettype wire

//--- src/sram_macro_model.sv
`default_nettype none

`include "sram_test_params.svh"

module sram_macro_model #(
  parameter int DATA_W      = 32,
  parameter bit HAS_RO_PORT = 1'b0
) (
  input  logic                       clk,
  input  sram_test_pkg::macro_pins_t pins,
  output logic [DATA_W-1:0]          rw_dout,
  output logic [DATA_W-1:0]          ro_dout
);

  localparam int BYTES = DATA_W / 8;

  logic                 cs_n;
  logic                 we_n;
  logic [BYTES-1:0]     wmask;
  logic [`ADDR_W-1:0]   addr;
  logic [DATA_W-1:0]    din;
  logic                 ro_cs_n;
  logic [`ADDR_W-1:0]   ro_addr;

  logic [DATA_W-1:0] mem [2**`ADDR_W];

  // Each macro width decodes its own view of the payload
  if (DATA_W == 64) begin : g_wide_view
    assign cs_n    = pins.payload.wide.csb0;
    assign we_n    = pins.payload.wide.web0;
    assign wmask   = pins.payload.wide.wmask;
    assign addr    = pins.payload.wide.addr0;
    assign din     = pins.payload.wide.din0;
    assign ro_cs_n = 1'b1;  // No second port in the wide layout
    assign ro_addr = '0;
  end else begin : g_narrow_view
    assign cs_n    = pins.payload.narrow.csb0;
    assign we_n    = pins.payload.narrow.web0;
    assign wmask   = pins.payload.narrow.wmask;
    assign addr    = pins.payload.narrow.addr0;
    assign din     = pins.payload.narrow.din0;
    assign ro_cs_n = pins.payload.narrow.csb1;
    assign ro_addr = pins.payload.narrow.addr1;
  end

  // Read/write port, access only on an active strobe
  always_ff @(posedge clk) begin
    if (pins.strobe && !cs_n) begin
      if (!we_n) begin
        for (int b = 0; b < BYTES; b++) begin
          if (wmask[b]) begin
            mem[addr][b*8 +: 8] <= din[b*8 +: 8];
          end
        end
      end else begin
        rw_dout <= mem[addr];
      end
    end
  end

  if (HAS_RO_PORT) begin : g_ro_port
    // Independent of csb0, paced by the same strobe
    always_ff @(posedge clk) begin
      if (pins.strobe && !ro_cs_n) begin
        ro_dout <= mem[ro_addr];
      end
    end
  end else begin : g_no_ro_port
    assign ro_dout = '0;
  end

endmodule

`default_nettype wire

//--- src/openram_testchip_top.sv
`default_nettype none

`include "sram_test_params.svh"

module openram_testchip_top (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        in_select,   // High selects the serial path
  input  logic                        gpio_bit,
  input  logic                        gpio_valid,
  input  sram_test_pkg::test_packet_t la_packet,
  output logic [63:0]                 sram_data
);

  import sram_test_pkg::*;

  test_packet_t serial_packet;
  test_packet_t active_packet;
  macro_pins_t  macro_pins [`NUM_MACROS];
  logic [31:0]  rw_dout0;
  logic [31:0]  ro_dout0;
  logic [31:0]  rw_dout1;
  logic [63:0]  rw_dout2;

  // Packet source mux
  assign active_packet = in_select ? serial_packet : la_packet;

  gpio_packet_deserializer u_deser (
    .clk        (clk),
    .reset      (reset),
    .gpio_bit   (gpio_bit),
    .gpio_valid (gpio_valid),
    .packet     (serial_packet)
  );

  sram_port_router u_router (
    .clk        (clk),
    .reset      (reset),
    .packet_in  (active_packet),
    .macro_pins (macro_pins),
    .rw_dout0   (rw_dout0),
    .ro_dout0   (ro_dout0),
    .rw_dout1   (rw_dout1),
    .rw_dout2   (rw_dout2),
    .sram_data  (sram_data)
  );

  // 32-bit, read/write plus read-only port
  sram_macro_model #(.DATA_W(32), .HAS_RO_PORT(1'b1)) u_macro0 (
    .clk     (clk),
    .pins    (macro_pins[0]),
    .rw_dout (rw_dout0),
    .ro_dout (ro_dout0)
  );

  sram_macro_model #(.DATA_W(32), .HAS_RO_PORT(1'b0)) u_macro1 (
    .clk     (clk),
    .pins    (macro_pins[1]),
    .rw_dout (rw_dout1),
    .ro_dout ()
  );

  // 64-bit
  sram_macro_model #(.DATA_W(64), .HAS_RO_PORT(1'b0)) u_macro2 (
    .clk     (clk),
    .pins    (macro_pins[2]),
    .rw_dout (rw_dout2),
    .ro_dout ()
  );

endmodule

`default_nettype wire

//--- tests/openram_testchip_tb.sv
`default_nettype none

`include "sram_test_params.svh"

module openram_testchip_tb;

  import sram_test_pkg::*;

  localparam int RESET_CYCLES   = 4;
  localparam int HOLD_CYCLES    = 8;  // Covers the worst strobe phase
  localparam int SERIAL_TIMEOUT = 4;

  logic         clk;
  logic         reset;
  logic         in_select;
  logic         gpio_bit;
  logic         gpio_valid;
  test_packet_t la_packet;
  logic [63:0]  sram_data;

  // Stimulus table, entry i sits at index i of every queue
  string        tc_name   [$];
  bit           tc_serial [$];
  test_packet_t tc_packet [$];
  bit           tc_check  [$];
  logic [63:0]  tc_expect [$];

  logic [63:0] ref_mem [`NUM_MACROS][2**`ADDR_W];  // Predicted macro contents

  openram_testchip_top dut (
    .clk        (clk),
    .reset      (reset),
    .in_select  (in_select),
    .gpio_bit   (gpio_bit),
    .gpio_valid (gpio_valid),
    .la_packet  (la_packet),
    .sram_data  (sram_data)
  );

  always #20 clk = ~clk;

  task automatic stop_on_failure();
    $display("Some tests failed");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic wait_cycles(input int count);
    for (int n = 0; n < count; n++) begin
      @(negedge clk);
    end
  endtask

  function automatic test_packet_t idle_packet();
    test_packet_t pkt;
    pkt = '0;
    pkt.sel = SEL_NONE;
    return pkt;
  endfunction

  function automatic test_packet_t narrow_packet(input macro_sel_e sel, input logic csb0,
                                                 input logic web0, input logic [3:0] wmask,
                                                 input logic [7:0] addr0,
                                                 input logic [31:0] din0, input logic csb1,
                                                 input logic [7:0] addr1);
    test_packet_t pkt;
    pkt = '0;
    pkt.sel = sel;
    pkt.payload.narrow.csb0  = csb0;
    pkt.payload.narrow.web0  = web0;
    pkt.payload.narrow.wmask = wmask;
    pkt.payload.narrow.addr0 = addr0;
    pkt.payload.narrow.din0  = din0;
    pkt.payload.narrow.csb1  = csb1;
    pkt.payload.narrow.addr1 = addr1;
    return pkt;
  endfunction

  function automatic test_packet_t wide_packet(input macro_sel_e sel, input logic csb0,
                                               input logic web0, input logic [7:0] wmask,
                                               input logic [7:0] addr0,
                                               input logic [63:0] din0);
    test_packet_t pkt;
    pkt = '0;
    pkt.sel = sel;
    pkt.payload.wide.csb0  = csb0;
    pkt.payload.wide.web0  = web0;
    pkt.payload.wide.wmask = wmask;
    pkt.payload.wide.addr0 = addr0;
    pkt.payload.wide.din0  = din0;
    return pkt;
  endfunction

  // Byte-masked write into the reference memory
  task automatic apply_write(input int idx, input logic [7:0] addr, input logic [7:0] mask,
                             input logic [63:0] data, input int nbytes);
    for (int b = 0; b < nbytes; b++) begin
      if (mask[b]) begin
        ref_mem[idx][addr][b*8 +: 8] = data[b*8 +: 8];
      end
    end
  endtask

  task automatic push_entry(input string name, input bit serial, input test_packet_t pkt,
                            input bit check, input logic [63:0] expected);
    tc_name.push_back(name);
    tc_serial.push_back(serial);
    tc_packet.push_back(pkt);
    tc_check.push_back(check);
    tc_expect.push_back(expected);
  endtask

  task automatic narrow_write(input string name, input bit serial, input macro_sel_e sel,
                              input logic [7:0] addr, input logic [3:0] mask,
                              input logic [31:0] data);
    push_entry(name, serial, narrow_packet(sel, 1'b0, 1'b0, mask, addr, data, 1'b1, 8'd0),
               1'b0, 64'd0);
    apply_write(int'(sel), addr, {4'd0, mask}, {32'd0, data}, 4);
  endtask

  task automatic narrow_read(input string name, input bit serial, input macro_sel_e sel,
                             input logic [7:0] addr);
    push_entry(name, serial, narrow_packet(sel, 1'b0, 1'b1, 4'd0, addr, 32'd0, 1'b1, 8'd0),
               1'b1, {32'd0, ref_mem[int'(sel)][addr][31:0]});  // Zero-extended
  endtask

  // Port 0 idle, read-only port reads addr1
  task automatic ro_port_read(input string name, input bit serial, input logic [7:0] addr1);
    push_entry(name, serial,
               narrow_packet(SEL_NARROW_DP, 1'b1, 1'b1, 4'd0, 8'd0, 32'd0, 1'b0, addr1),
               1'b1, {32'd0, ref_mem[0][addr1][31:0]});
  endtask

  task automatic wide_write(input string name, input bit serial, input logic [7:0] addr,
                            input logic [7:0] mask, input logic [63:0] data);
    push_entry(name, serial, wide_packet(SEL_WIDE, 1'b0, 1'b0, mask, addr, data),
               1'b0, 64'd0);
    apply_write(2, addr, mask, data, 8);
  endtask

  task automatic wide_read(input string name, input bit serial, input logic [7:0] addr);
    push_entry(name, serial, wide_packet(SEL_WIDE, 1'b0, 1'b1, 8'd0, addr, 64'd0),
               1'b1, ref_mem[2][addr]);
  endtask

  // Nothing selected, so no reference update and reads give zero
  task automatic none_access(input string name, input bit serial, input bit wide,
                             input logic web0, input logic [7:0] addr,
                             input logic [63:0] data);
    test_packet_t pkt;
    if (wide) begin
      pkt = wide_packet(SEL_NONE, 1'b0, web0, 8'hff, addr, data);
    end else begin
      pkt = narrow_packet(SEL_NONE, 1'b0, web0, 4'hf, addr, data[31:0], 1'b1, 8'd0);
    end
    push_entry(name, serial, pkt, web0, 64'd0);
  endtask

  task automatic build_table();
    narrow_write("m1_write_full", 1'b0, SEL_NARROW_SP, 8'h21, 4'hf, $urandom());
    narrow_read("m1_read_full", 1'b0, SEL_NARROW_SP, 8'h21);
    wide_write("m2_write_full", 1'b0, 8'h5a, 8'hff, {$urandom(), $urandom()});
    wide_read("m2_read_full", 1'b0, 8'h5a);
    narrow_write("m1_write_partial", 1'b0, SEL_NARROW_SP, 8'h21, 4'b0101, $urandom());
    narrow_read("m1_read_partial", 1'b0, SEL_NARROW_SP, 8'h21);
    wide_write("m2_write_partial", 1'b0, 8'h5a, 8'b1001_0110, {$urandom(), $urandom()});
    wide_read("m2_read_partial", 1'b0, 8'h5a);
    narrow_write("m0_write_a", 1'b0, SEL_NARROW_DP, 8'h33, 4'hf, $urandom());
    narrow_write("m0_write_b", 1'b0, SEL_NARROW_DP, 8'h34, 4'hf, $urandom());
    narrow_read("m0_rw_read_b", 1'b0, SEL_NARROW_DP, 8'h34);
    ro_port_read("m0_ro_read_a", 1'b0, 8'h33);
    ro_port_read("m0_ro_read_b", 1'b0, 8'h34);
    wide_write("ser_m2_write", 1'b1, 8'h77, 8'hff, {$urandom(), $urandom()});
    wide_read("ser_m2_read", 1'b1, 8'h77);
    narrow_write("ser_m1_write", 1'b1, SEL_NARROW_SP, 8'h90, 4'hf, $urandom());
    narrow_read("ser_m1_read", 1'b1, SEL_NARROW_SP, 8'h90);
    ro_port_read("ser_m0_ro_read", 1'b1, 8'h33);
    narrow_read("par_m1_read_serial_data", 1'b0, SEL_NARROW_SP, 8'h90);
    none_access("none_write_narrow", 1'b0, 1'b0, 1'b0, 8'h21, {$urandom(), $urandom()});
    none_access("none_write_wide", 1'b1, 1'b1, 1'b0, 8'h5a, {$urandom(), $urandom()});
    narrow_read("m1_read_after_none", 1'b0, SEL_NARROW_SP, 8'h21);
    wide_read("m2_read_after_none", 1'b0, 8'h5a);
    none_access("none_read", 1'b0, 1'b0, 1'b1, 8'h21, 64'd0);
  endtask

  // MSB first, one bit per cycle
  task automatic shift_packet(input test_packet_t pkt);
    for (int i = `PACKET_W - 1; i >= 0; i--) begin
      gpio_valid = 1'b1;
      gpio_bit   = pkt[i];
      @(negedge clk);
    end
    gpio_valid = 1'b0;
    gpio_bit   = 1'b0;
  endtask

  task automatic wait_serial_packet(input string name, input test_packet_t pkt);
    logic seen;
    seen = 1'b0;
    for (int n = 0; n < SERIAL_TIMEOUT && !seen; n++) begin
      if (dut.u_deser.packet == pkt) begin
        seen = 1'b1;
      end else begin
        @(negedge clk);
      end
    end
    if (!seen) begin
      $display("Timeout in %s, the serial packet never reached the deserializer output", name);
      stop_on_failure();
    end
  endtask

  task automatic check_result(input string name, input logic [63:0] expected);
    assert (sram_data === expected) else begin
      $display("error: %s expected %h actual %h", name, expected, sram_data);
      stop_on_failure();
    end
  endtask

  initial begin
    void'($urandom(32'hbe739227));
    clk        = 1'b0;
    reset      = 1'b1;
    in_select  = 1'b0;
    gpio_bit   = 1'b0;
    gpio_valid = 1'b0;
    la_packet  = idle_packet();
    build_table();
    wait_cycles(RESET_CYCLES);
    reset = 1'b0;
    check_result("reset_state", 64'd0);
    for (int i = 0; i < tc_name.size(); i++) begin
      in_select = 1'b0;
      if (tc_serial[i]) begin
        la_packet = idle_packet();  // Parallel side stays quiet while shifting
        shift_packet(tc_packet[i]);
        wait_serial_packet(tc_name[i], tc_packet[i]);
        in_select = 1'b1;
      end else begin
        la_packet = tc_packet[i];
      end
      wait_cycles(HOLD_CYCLES);
      if (tc_check[i]) begin
        check_result(tc_name[i], tc_expect[i]);
      end
    end
    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- openram_testchip.f
+incdir+src
src/sram_test_pkg.sv
src/gpio_packet_deserializer.sv
src/sram_port_router.sv
src/sram_macro_model.sv
src/openram_testchip_top.sv
tests/openram_testchip_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, decide the result from the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=openram_testchip_sim
LOG=sim.log

verilator --binary --timing --assert \
  -f openram_testchip.f \
  --top-module openram_testchip_tb \
  -Mdir "$BUILD_DIR" -o "$SIM_BIN"
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
fi

if grep -qx "All tests passed" "$LOG"; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1
